//--- files.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_ctrl_regs.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the icache testbench with verilator and runs it from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module icache_tb -f files.f -o icache_sim
./obj_dir/icache_sim 2>&1 | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- test/icache_tb.sv
// run from the project root so the data file path resolves; the refill model serves one cycle at a time
`timescale 1ns/1ns

module icache_tb;

  localparam int CLK_HALF = 20;
  localparam int TD_OPS   = 40;
  localparam int TD_COLS  = 5;

  // opcodes of the data file
  localparam logic [31:0] OP_END   = 32'd0;
  localparam logic [31:0] OP_FETCH = 32'd1;
  localparam logic [31:0] OP_WRITE = 32'd2;
  localparam logic [31:0] OP_READ  = 32'd3;
  localparam logic [31:0] OP_WAIT  = 32'd4;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  icache_pkg::fetch_req_t fetch_req;
  icache_pkg::fetch_rsp_t fetch_rsp;
  icache_pkg::wb_line_m_t line_m;
  icache_pkg::wb_line_s_t line_s = '0;
  icache_pkg::wb_reg_m_t  reg_m;
  icache_pkg::wb_reg_s_t  reg_s;

  logic [31:0] td_mem [0:TD_OPS*TD_COLS-1];
  int unsigned n_ops;
  int unsigned err_cnt;
  // shadow of the enable bit, decides the expected refill address form
  logic        cache_on;
  // refill slave state
  logic        mem_busy = 1'b0;
  int unsigned ack_wait = 0;

  always #CLK_HALF clk_i = ~clk_i;

  icache_top dut0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .fetch_i   (fetch_req),
    .fetch_o   (fetch_rsp),
    .wb_line_o (line_m),
    .wb_line_i (line_s),
    .wb_reg_i  (reg_m),
    .wb_reg_o  (reg_s)
  );

  //////////////////////////////
  // memory model
  //////////////////////////////

  // each word is its own byte address xor 5a5a0000, uncached answers fill every lane
  function automatic logic [127:0] line_for(input logic [31:0] adr, input logic nc);
    logic [127:0] line;
    logic [31:0]  word_adr;
    line = '0;
    for (int i = 0; i < 4; i++) begin
      word_adr = nc ? {adr[31:2], 2'b00} : {adr[31:4], i[1:0], 2'b00};
      line[i*32 +: 32] = word_adr ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  always @(negedge clk_i) begin
    if (line_s.ack) begin
      line_s.ack = 1'b0;
      mem_busy   = 1'b0;
    end else if (line_m.cyc && line_m.stb) begin
      // new bus cycle draws its ack delay
      if (!mem_busy) begin
        mem_busy = 1'b1;
        ack_wait = $urandom_range(5, 0);
      end
      if (ack_wait == 0) begin
        line_s.data = line_for(line_m.adr, line_m.nc_o);
        line_s.ack  = 1'b1;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  //////////////////////////////
  // helper tasks
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fetch_word(input logic [31:0] addr, input logic [31:0] exp_word,
                            input logic exp_refill);
    logic        refill_seen;
    logic [31:0] refill_adr;
    logic        refill_nc;
    logic [31:0] exp_adr;
    logic        exp_nc;
    refill_seen = 1'b0;
    refill_adr  = '0;
    refill_nc   = 1'b0;
    @(negedge clk_i);
    fetch_req.req  = 1'b1;
    fetch_req.addr = addr;
    // ready only moves on rising edges
    while (!fetch_rsp.ready) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    fetch_req.req = 1'b0;
    // watch the refill port until the response pulse
    while (!fetch_rsp.valid) begin
      if (line_m.cyc) begin
        refill_seen = 1'b1;
        refill_adr  = line_m.adr;
        refill_nc   = line_m.nc_o;
      end
      @(negedge clk_i);
    end
    check_value("fetch_o.data", fetch_rsp.data, exp_word);
    check_value("wb_line_o.cyc seen", {31'd0, refill_seen}, {31'd0, exp_refill});
    if (refill_seen) begin
      // uncached refills present the word address, cached ones the line address
      exp_nc = !cache_on || addr[31];
      if (exp_nc) begin
        exp_adr = {addr[31:2], 2'b00};
      end else begin
        exp_adr = {addr[31:4], 4'h0};
      end
      check_value("wb_line_o.adr", refill_adr, exp_adr);
      check_value("wb_line_o.nc_o", {31'd0, refill_nc}, {31'd0, exp_nc});
    end
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
    @(negedge clk_i);
    reg_m.cyc   = 1'b1;
    reg_m.stb   = 1'b1;
    reg_m.we    = 1'b1;
    reg_m.adr   = adr;
    reg_m.wdata = data;
    @(negedge clk_i);
    while (!reg_s.ack) begin
      @(negedge clk_i);
    end
    // hold through the ack edge, the write lands there
    @(negedge clk_i);
    reg_m = '0;
  endtask

  task automatic read_reg(input logic [3:0] adr, output logic [31:0] data);
    @(negedge clk_i);
    reg_m.cyc = 1'b1;
    reg_m.stb = 1'b1;
    reg_m.we  = 1'b0;
    reg_m.adr = adr;
    @(negedge clk_i);
    while (!reg_s.ack) begin
      @(negedge clk_i);
    end
    data = reg_s.rdata;
    @(negedge clk_i);
    reg_m = '0;
  endtask

  task automatic idle_cycles(input logic [31:0] n);
    repeat (n) @(negedge clk_i);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [31:0] refill;
    logic [31:0] rdata;
    void'($urandom(32'h950d));
    rst_ni    = 1'b0;
    fetch_req = '0;
    reg_m     = '0;
    cache_on  = 1'b0;
    err_cnt   = 0;
    for (int i = 0; i < TD_OPS * TD_COLS; i++) begin
      td_mem[i] = '0;
    end
    $readmemh("test/icache_testdata.txt", td_mem);
    // an opcode of zero ends the list
    n_ops = 0;
    while (n_ops < TD_OPS && td_mem[n_ops*TD_COLS] != OP_END) begin
      n_ops++;
    end
    if (n_ops == 0) begin
      $display("** FAIL **");
      $fatal(1, "no operations could be read from the data file");
    end
    fork
      begin
        repeat (n_ops * 200) @(posedge clk_i);
        $display("** FAIL **");
        $fatal(1, "timeout, the test did not finish within %0d cycles", n_ops * 200);
      end
    join_none
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int unsigned k = 0; k < n_ops; k++) begin
      op     = td_mem[k*TD_COLS];
      addr   = td_mem[k*TD_COLS+1];
      data   = td_mem[k*TD_COLS+2];
      expv   = td_mem[k*TD_COLS+3];
      refill = td_mem[k*TD_COLS+4];
      case (op)
        OP_FETCH: fetch_word(addr, expv, refill[0]);
        OP_WRITE: begin
          write_reg(addr[3:0], data);
          if (addr[3:0] == 4'd0) begin
            cache_on = data[0];
          end
        end
        OP_READ: begin
          read_reg(addr[3:0], rdata);
          check_value("wb_reg_o.rdata", rdata, expv);
        end
        OP_WAIT: idle_cycles(data);
        default: begin
          $display("** FAIL **");
          $fatal(1, "unknown opcode %h in data line %0d", op, k);
        end
      endcase
    end
    repeat (4) @(negedge clk_i);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- test/icache_testdata.txt
// columns: opcode address data expected refill (1 fetch, 2 reg write, 3 reg read, 4 wait, 0 end)
// a fetch expects its word's byte address xor 5a5a0000; wait uses the data column as cycles
// cache disabled after reset, every fetch refills and nothing is counted
1 00000100 00000000 5a5a0100 1
1 00000104 00000000 5a5a0104 1
1 00000104 00000000 5a5a0104 1
3 00000004 00000000 00000000 0
3 00000000 00000000 00000000 0
// enable, the first touch of a line misses and the rest of the line hits
2 00000000 00000001 00000000 0
4 00000000 00000014 00000000 0
3 00000000 00000000 00000001 0
1 00000108 00000000 5a5a0108 1
1 00000100 00000000 5a5a0100 0
1 0000010c 00000000 5a5a010c 0
1 00000104 00000000 5a5a0104 0
3 00000004 00000000 00000001 0
// i/o region always refills with a word address
1 80000104 00000000 da5a0104 1
1 80000104 00000000 da5a0104 1
// two tags in set 3 fill both ways
1 00000234 00000000 5a5a0234 1
1 00001238 00000000 5a5a1238 1
1 00000230 00000000 5a5a0230 0
1 0000123c 00000000 5a5a123c 0
3 00000004 00000000 00000003 0
// flush keeps the counter, resident lines miss again
2 00000000 00000003 00000000 0
1 00000100 00000000 5a5a0100 1
1 00000230 00000000 5a5a0230 1
1 00000234 00000000 5a5a0234 0
3 00000004 00000000 00000005 0
0 00000000 00000000 00000000 0

//--- verilog/icache_ctrl.sv
// fetch fsm and single-beat refill master; responses cannot be stalled and ack wait is unbounded
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  icache_pkg::fetch_req_t        fetch_i,
  output icache_pkg::fetch_rsp_t        fetch_o,
  output icache_pkg::wb_line_m_t        wb_line_o,
  input  icache_pkg::wb_line_s_t        wb_line_i,
  input  icache_pkg::cache_cfg_t        cfg_i,
  input  icache_pkg::tag_lookup_t       lookup_i,
  input  logic                          clear_done_i,
  input  logic [`ICACHE_WORD_W-1:0]     word_i,
  output logic                          rd_o,
  output logic                          wr_o,
  output logic                          clear_o,
  output logic [`ICACHE_IDX_W-1:0]      idx_o,
  output logic [`ICACHE_TAG_W-1:0]      tag_o,
  output logic [`ICACHE_OFS_W-3:0]      ofs_o,
  output logic                          use_fill_o,
  output logic                          flush_ack_o,
  output logic                          miss_o
);

  icache_pkg::icache_state_e state_q, state_d;
  logic                      en_q, en_d;
  logic                      nc_q, nc_d;
  logic                      fill_vld_q;
  logic [`ICACHE_ADDR_W-1:0] addr_q;
  logic                      ready;
  logic                      accept;
  logic                      go_flush;
  logic                      cached_hit;
  logic                      fill_ack;

  // pending flush, or cache just switched on
  assign go_flush = cfg_i.flush_req | (cfg_i.enable & ~en_q);

  // hit only counts for cacheable addresses with the cache on
  assign cached_hit = (state_q == icache_pkg::READ) & en_q & ~addr_q[`ICACHE_ADDR_W-1]
                    & lookup_i.hit;
  assign fill_ack   = (state_q == icache_pkg::MISS) & wb_line_i.ack;

  assign ready  = ((state_q == icache_pkg::IDLE) | cached_hit) & ~go_flush;
  assign accept = ready & fetch_i.req;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    // turning off is immediate, turning on goes through FLUSH
    en_d    = en_q & cfg_i.enable;
    nc_d    = nc_q;
    unique case (state_q)
      icache_pkg::FLUSH: begin
        if (clear_done_i) begin
          state_d = icache_pkg::IDLE;
          en_d    = cfg_i.enable;
        end
      end
      icache_pkg::IDLE: begin
        if (go_flush) begin
          state_d = icache_pkg::FLUSH;
        end else if (accept) begin
          state_d = icache_pkg::READ;
        end
      end
      icache_pkg::READ: begin
        if (cached_hit) begin
          // back-to-back hits stay in READ
          state_d = accept ? icache_pkg::READ : icache_pkg::IDLE;
        end else begin
          // miss, i/o region or disabled cache all use the refill path
          state_d = icache_pkg::MISS;
          nc_d    = ~en_q | addr_q[`ICACHE_ADDR_W-1];
        end
      end
      icache_pkg::MISS: begin
        if (wb_line_i.ack) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= icache_pkg::FLUSH;
      en_q       <= 1'b0;
      nc_q       <= 1'b0;
      fill_vld_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      en_q       <= en_d;
      nc_q       <= nc_d;
      fill_vld_q <= fill_ack;
    end
  end

  // request address, held through READ and MISS
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_i.addr;
    end
  end

  //////////////////////////////
  // array strobes
  //////////////////////////////

  assign rd_o        = accept;
  // nc refills bypass the arrays
  assign wr_o        = fill_ack & ~nc_q;
  assign miss_o      = fill_ack & ~nc_q;
  assign use_fill_o  = fill_ack;
  assign clear_o     = (state_q == icache_pkg::FLUSH);
  assign flush_ack_o = (state_q == icache_pkg::FLUSH);

  // new index on lookup, held index for the refill write
  assign idx_o = accept ? fetch_i.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W]
                        : addr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  // tag store keeps its own copy at rd_o
  assign tag_o = fetch_i.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign ofs_o = fetch_i.addr[`ICACHE_OFS_W-1:2];

  //////////////////////////////
  // refill master and response
  //////////////////////////////

  assign wb_line_o.cyc  = (state_q == icache_pkg::MISS);
  assign wb_line_o.stb  = (state_q == icache_pkg::MISS);
  // word address for nc, line address otherwise
  assign wb_line_o.adr  = nc_q ? {addr_q[`ICACHE_ADDR_W-1:2], 2'b00}
                               : {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
  assign wb_line_o.nc_o = nc_q;

  assign fetch_o.ready = ready;
  assign fetch_o.valid = cached_hit | fill_vld_q;
  assign fetch_o.data  = word_i;

endmodule

//--- verilog/icache_ctrl_regs.sv
// wishbone classic slave, acks one cycle after a request; flush bit reads back as 0
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::wb_reg_m_t  wb_reg_i,
  output icache_pkg::wb_reg_s_t  wb_reg_o,
  input  logic                   flush_ack_i,
  input  logic                   miss_i,
  output icache_pkg::cache_cfg_t cfg_o
);

  logic                ack_q;
  logic                enable_q;
  logic                flush_q;
  logic [31:0]         miss_cnt_q;
  icache_pkg::reg_op_e op;

  // access is acted on in the ack cycle, master holds its signals until then
  always_comb begin
    op = icache_pkg::REG_NONE;
    if (ack_q) begin
      op = wb_reg_i.we ? icache_pkg::REG_WRITE : icache_pkg::REG_READ;
    end
  end

  //////////////////////////////
  // state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      enable_q   <= 1'b0;
      flush_q    <= 1'b0;
      miss_cnt_q <= '0;
    end else begin
      // single-cycle ack, then wait for the next strobe
      ack_q <= wb_reg_i.cyc & wb_reg_i.stb & ~ack_q;
      if (flush_ack_i) begin
        flush_q <= 1'b0;
      end
      // a new flush write wins over the controller's acknowledge
      if (op == icache_pkg::REG_WRITE && wb_reg_i.adr == `ICACHE_REG_CTRL) begin
        enable_q <= wb_reg_i.wdata[0];
        if (wb_reg_i.wdata[1]) begin
          flush_q <= 1'b1;
        end
      end
      // counts cached misses only
      if (miss_i) begin
        miss_cnt_q <= miss_cnt_q + 32'd1;
      end
    end
  end

  // read mux, zero outside a read ack
  always_comb begin
    wb_reg_o.ack   = ack_q;
    wb_reg_o.rdata = '0;
    if (op == icache_pkg::REG_READ) begin
      if (wb_reg_i.adr == `ICACHE_REG_CTRL) begin
        wb_reg_o.rdata = {31'd0, enable_q};
      end else if (wb_reg_i.adr == `ICACHE_REG_MISS) begin
        wb_reg_o.rdata = miss_cnt_q;
      end
    end
  end

  assign cfg_o.enable    = enable_q;
  assign cfg_o.flush_req = flush_q;

endmodule

//--- verilog/icache_data_store.sv
// line data per way; the refill word is captured on the ack cycle for the next-cycle response
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_data_store (
  input  logic                          clk_i,
  input  logic                          rd_i,
  input  logic                          wr_i,
  input  logic [`ICACHE_IDX_W-1:0]      idx_i,
  input  logic [`ICACHE_OFS_W-3:0]      ofs_i,
  input  icache_pkg::tag_lookup_t       lookup_i,
  input  logic [`ICACHE_LINE_W-1:0]     line_i,
  input  logic                          use_fill_i,
  output logic [`ICACHE_WORD_W-1:0]     word_o
);

  logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_LINE_W-1:0] line_rd_q [`ICACHE_WAYS];
  logic [`ICACHE_OFS_W-3:0]  ofs_q;
  logic [`ICACHE_WORD_W-1:0] fill_word_q;
  logic                      fill_sel_q;

  always_ff @(posedge clk_i) begin
    // both ways read in parallel, hit way picked afterwards
    if (rd_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        line_rd_q[w] <= line_mem[w][idx_i];
      end
      ofs_q <= ofs_i;
    end
    if (wr_i) begin
      line_mem[lookup_i.repl_way][idx_i] <= line_i;
    end
    // uncached refills also land here, they never touch the array
    if (use_fill_i) begin
      fill_word_q <= line_i[ofs_q * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    end
    fill_sel_q <= use_fill_i;
  end

  // refill word in the cycle after ack, else word of the hit way
  assign word_o = fill_sel_q ? fill_word_q :
                  line_rd_q[lookup_i.hit_way][ofs_q * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

//--- verilog/icache_defines.svh
// sizes are fixed here; way-select logic assumes exactly two ways and a power-of-two set count
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////
// address and data widths
//////////////////////////////

// byte address, top bit selects the uncached i/o region
`define ICACHE_ADDR_W 32
// fetch word returned to the cpu
`define ICACHE_WORD_W 32
// one cache line, also the refill beat width
`define ICACHE_LINE_W 128

//////////////////////////////
// cache geometry
//////////////////////////////

`define ICACHE_WAYS 2
`define ICACHE_SETS 16
// byte offset inside a line
`define ICACHE_OFS_W 4
// set index bits
`define ICACHE_IDX_W 4
// remaining upper address bits
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)
// replacement lfsr
`define ICACHE_LFSR_W 8

// register offsets on the 4-bit register port
`define ICACHE_REG_CTRL 4'd0
`define ICACHE_REG_MISS 4'd4

`endif

//--- verilog/icache_pkg.sv
// shared types only; struct widths follow the sizes in the defines header
`include "icache_defines.svh"

package icache_pkg;

  // controller states, FLUSH is the reset state
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } icache_state_e;

  // register access kind, decoded on the ack cycle
  typedef enum logic [1:0] {
    REG_NONE,
    REG_READ,
    REG_WRITE
  } reg_op_e;

  //////////////////////////////
  // fetch port
  //////////////////////////////

  typedef struct packed {
    logic                      req;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                      ready;
    logic                      valid;
    logic [`ICACHE_WORD_W-1:0] data;
  } fetch_rsp_t;

  //////////////////////////////
  // wishbone refill master
  //////////////////////////////

  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic [`ICACHE_ADDR_W-1:0] adr;
    // set for word-sized uncached refills
    logic                      nc_o;
  } wb_line_m_t;

  typedef struct packed {
    logic                      ack;
    logic [`ICACHE_LINE_W-1:0] data;
  } wb_line_s_t;

  //////////////////////////////
  // wishbone register slave
  //////////////////////////////

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] wdata;
  } wb_reg_m_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } wb_reg_s_t;

  // register block toward controller
  typedef struct packed {
    logic enable;
    logic flush_req;
  } cache_cfg_t;

  // tag store result, valid in the cycle after a read strobe
  typedef struct packed {
    logic hit;
    logic hit_way;
    logic repl_way;
  } tag_lookup_t;

endpackage

//--- verilog/icache_tag_store.sv
// two-way tag and valid arrays; valid bits are only defined after the first clear sweep
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_tag_store (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_i,
  input  logic [`ICACHE_IDX_W-1:0]      idx_i,
  input  logic [`ICACHE_TAG_W-1:0]      tag_i,
  input  logic                          wr_i,
  input  logic                          clear_i,
  output logic                          clear_done_o,
  output icache_pkg::tag_lookup_t       lookup_o
);

  // arrays
  logic [`ICACHE_TAG_W-1:0]  tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]   vld_mem [`ICACHE_WAYS];

  // read side, one cycle after rd_i
  logic [`ICACHE_TAG_W-1:0]  tag_rd_q [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]   vld_rd_q;
  logic [`ICACHE_TAG_W-1:0]  tag_q;
  logic [`ICACHE_WAYS-1:0]   hit_vec;
  logic                      all_valid;

  // sweep counter and replacement lfsr
  logic [`ICACHE_IDX_W-1:0]  clr_cnt_q;
  logic [`ICACHE_LFSR_W-1:0] lfsr_q;
  logic                      lfsr_fb;

  assign clear_done_o = clear_i & (clr_cnt_q == {`ICACHE_IDX_W{1'b1}});

  //////////////////////////////
  // control state
  //////////////////////////////

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_cnt_q <= '0;
      lfsr_q    <= 8'h01;
    end else begin
      if (clear_done_o) begin
        clr_cnt_q <= '0;
      end else if (clear_i) begin
        clr_cnt_q <= clr_cnt_q + 1'b1;
      end
      // only step when a full set loses a line
      if (wr_i && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

  //////////////////////////////
  // arrays
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        tag_rd_q[w] <= tag_mem[w][idx_i];
        vld_rd_q[w] <= vld_mem[w][idx_i];
      end
      tag_q <= tag_i;
    end
    // sweep clears one set in both ways per cycle
    if (clear_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        vld_mem[w][clr_cnt_q] <= 1'b0;
      end
    end
    // refill writes the tag captured at lookup time
    if (wr_i) begin
      tag_mem[lookup_o.repl_way][idx_i] <= tag_q;
      vld_mem[lookup_o.repl_way][idx_i] <= 1'b1;
    end
  end

  // compare against the registered request tag
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_vec[w] = vld_rd_q[w] & (tag_rd_q[w] == tag_q);
    end
  end

  assign all_valid = &vld_rd_q;

  assign lookup_o.hit      = |hit_vec;
  // way 0 wins, only meaningful with hit set
  assign lookup_o.hit_way  = ~hit_vec[0];
  // lowest invalid way first, random once the set is full
  assign lookup_o.repl_way = ~vld_rd_q[0] ? 1'b0 :
                             ~vld_rd_q[1] ? 1'b1 : lfsr_q[0];

endmodule

//--- verilog/icache_top.sv
// icache top; register port and refill port share the one clock, no reset synchronizer inside
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::fetch_req_t fetch_i,
  output icache_pkg::fetch_rsp_t fetch_o,
  output icache_pkg::wb_line_m_t wb_line_o,
  input  icache_pkg::wb_line_s_t wb_line_i,
  input  icache_pkg::wb_reg_m_t  wb_reg_i,
  output icache_pkg::wb_reg_s_t  wb_reg_o
);

  icache_pkg::cache_cfg_t    cfg;
  icache_pkg::tag_lookup_t   lookup;
  logic                      clear_done;
  logic                      rd;
  logic                      wr;
  logic                      clear;
  logic [`ICACHE_IDX_W-1:0]  idx;
  logic [`ICACHE_TAG_W-1:0]  tag;
  logic [`ICACHE_OFS_W-3:0]  ofs;
  logic                      use_fill;
  logic                      flush_ack;
  logic                      miss;
  logic [`ICACHE_WORD_W-1:0] word;

  // enable, flush command and miss counter
  icache_ctrl_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_reg_i    (wb_reg_i),
    .wb_reg_o    (wb_reg_o),
    .flush_ack_i (flush_ack),
    .miss_i      (miss),
    .cfg_o       (cfg)
  );

  icache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_i      (fetch_i),
    .fetch_o      (fetch_o),
    .wb_line_o    (wb_line_o),
    .wb_line_i    (wb_line_i),
    .cfg_i        (cfg),
    .lookup_i     (lookup),
    .clear_done_i (clear_done),
    .word_i       (word),
    .rd_o         (rd),
    .wr_o         (wr),
    .clear_o      (clear),
    .idx_o        (idx),
    .tag_o        (tag),
    .ofs_o        (ofs),
    .use_fill_o   (use_fill),
    .flush_ack_o  (flush_ack),
    .miss_o       (miss)
  );

  icache_tag_store u_tags (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_i         (rd),
    .idx_i        (idx),
    .tag_i        (tag),
    .wr_i         (wr),
    .clear_i      (clear),
    .clear_done_o (clear_done),
    .lookup_o     (lookup)
  );

  // refill data comes straight off the wishbone slave
  icache_data_store u_data (
    .clk_i      (clk_i),
    .rd_i       (rd),
    .wr_i       (wr),
    .idx_i      (idx),
    .ofs_i      (ofs),
    .lookup_i   (lookup),
    .line_i     (wb_line_i.data),
    .use_fill_i (use_fill),
    .word_o     (word)
  );

endmodule
